// ==== filelist.f ====
src/cache_pkg.sv
src/icache.sv
src/dcache.sv
src/main_mem_ctrl.sv
src/cache_top.sv
verif/cache_checker.sv
verif/tb_clkgen.sv
verif/tb_monitor.sv
verif/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module tb_top --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# keep running past assertion errors so the testbench prints its summary
out=$(./obj_dir/sim_tb +verilator+error+limit+1000 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

	localparam int MEM_LAT    = 3;
	localparam int N_OPS      = 400;
	localparam int RST_CYCLES = 8;
	// up to two memory operations per access, with margin
	localparam int TIMEOUT    = N_OPS * 2 * (MEM_LAT + 2) * 2 + RST_CYCLES;

	logic        clk;
	logic        rst;
	logic [15:0] i_addr;
	logic [15:0] instr;
	logic        i_hit;
	logic [15:0] d_addr;
	logic        d_re;
	logic        d_we;
	logic [15:0] d_wdata;
	logic [15:0] d_rdata;
	logic        d_hit;
	logic        data_finished;
	int          instr_errs;
	int          data_errs;
	int          proto_errs;
	int          overlaps;
	int          assert_errs;
	int          total_errs;
	int          cycle_count;

	tb_clkgen #(.RST_CYCLES(RST_CYCLES)) u_clkgen (.o_clk(clk), .o_rst(rst));

	cache_top #(
		.MEM_LAT (MEM_LAT)
	) dut0 (
		.clk       (clk),
		.rst       (rst),
		.i_i_addr  (i_addr),
		.i_d_addr  (d_addr),
		.i_d_re    (d_re),
		.i_d_we    (d_we),
		.i_d_wdata (d_wdata),
		.o_instr   (instr),
		.o_i_hit   (i_hit),
		.o_d_rdata (d_rdata),
		.o_d_hit   (d_hit)
	);

	tb_monitor u_monitor (
		.clk          (clk),
		.rst          (rst),
		.i_i_addr     (i_addr),
		.i_instr      (instr),
		.i_i_hit      (i_hit),
		.i_d_addr     (d_addr),
		.i_d_re       (d_re),
		.i_d_we       (d_we),
		.i_d_wdata    (d_wdata),
		.i_d_rdata    (d_rdata),
		.i_d_hit      (d_hit),
		.o_instr_errs (instr_errs),
		.o_data_errs  (data_errs),
		.o_proto_errs (proto_errs),
		.o_overlaps   (overlaps)
	);

	bind main_mem_ctrl cache_checker u_chk (
		.clk       (clk),
		.rst       (rst),
		.i_i_req   (i_i_req),
		.i_i_addr  (i_i_addr),
		.i_d_req   (i_d_req),
		.i_d_we    (i_d_we),
		.i_d_addr  (i_d_addr),
		.i_d_wline (i_d_wline),
		.i_i_done  (o_i_done),
		.i_d_done  (o_d_done)
	);

	assign assert_errs = dut0.u_mem.u_chk.fail_count;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////////////////////////
	// processor side
	////////////////////////////////////////

	// held until the cache reports a hit
	task automatic data_access(input logic [15:0] addr, input logic we, input logic [15:0] wdata);
		d_addr  = addr;
		d_re    = !we;
		d_we    = we;
		d_wdata = wdata;
		@(negedge clk);
		while (!d_hit) @(negedge clk);
		@(posedge clk);
		#1;
		d_re = 1'b0;
		d_we = 1'b0;
	endtask

	task automatic fetch(input logic [15:0] addr);
		i_addr = addr;
		@(negedge clk);
		while (!i_hit) @(negedge clk);
		@(posedge clk);
		#1;
	endtask

	// four tags over four sets, upper half of memory
	task automatic run_data;
		logic [31:0] rng;
		logic [13:0] line;
		rng  = 32'd61;
		line = '0;
		for (int n = 0; n < N_OPS; n++) begin
			rng = xorshift32(rng);
			// a quarter go back to the line just used
			if (n == 0 || rng[1:0] != 2'b00) begin
				line = {1'b1, 6'd0, rng[3:2], 3'd0, rng[5:4]};
			end
			data_access({line, rng[7:6]}, rng[8], rng[31:16]);
			if (rng[10:9] == 2'b00) begin
				repeat (rng[11] ? 2 : 1) begin
					@(posedge clk);
					#1;
				end
			end
		end
	endtask

	// mostly sequential, jumps keep index conflicts coming
	task automatic run_instr;
		logic [31:0] rng;
		logic [15:0] pc;
		rng = 32'd61 ^ 32'h9e37_79b9;
		pc  = 16'h0000;
		while (!data_finished) begin
			fetch(pc);
			rng = xorshift32(rng);
			if (rng[2:0] == 3'b000) begin
				pc = {4'h0, rng[19:8]};
			end else begin
				pc = (pc + 16'd1) & 16'h7fff;
			end
		end
	endtask

	////////////////////////////////////////
	// run control
	////////////////////////////////////////

	initial begin
		i_addr        = 16'h0000;
		d_addr        = 16'h8000;
		d_re          = 1'b0;
		d_we          = 1'b0;
		d_wdata       = 16'h0000;
		data_finished = 1'b0;
		wait (rst === 1'b0);
		@(posedge clk);
		#1;
		fork
			begin
				run_data();
				data_finished = 1'b1;
			end
			run_instr();
		join
		repeat (2) @(posedge clk);
		total_errs = instr_errs + data_errs + proto_errs + assert_errs;
		if (overlaps == 0) begin
			$display("no cycle had an instruction miss and a data miss outstanding together");
			total_errs = total_errs + 1;
		end
		$display("errors: instr %0d, data %0d, protocol %0d, assertion %0d (overlap cycles %0d)",
			instr_errs, data_errs, proto_errs, assert_errs, overlaps);
		if (total_errs == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT) begin
			@(posedge clk);
			cycle_count = cycle_count + 1;
		end
		$display("timeout: the run stalled and did not finish within %0d cycles", TIMEOUT);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== verif/tb_monitor.sv ====
`timescale 1ns/1ps

module tb_monitor (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] i_i_addr,
	input  logic [15:0] i_instr,
	input  logic        i_i_hit,
	input  logic [15:0] i_d_addr,
	input  logic        i_d_re,
	input  logic        i_d_we,
	input  logic [15:0] i_d_wdata,
	input  logic [15:0] i_d_rdata,
	input  logic        i_d_hit,
	output int          o_instr_errs,
	output int          o_data_errs,
	output int          o_proto_errs,
	output int          o_overlaps
);

	// words written so far, every other word still holds its own address
	logic [15:0] written [logic [15:0]];
	logic [13:0] last_line  = '0;
	logic        have_last  = 1'b0;
	logic        pending    = 1'b0;
	logic [15:0] expected;
	int          instr_errs = 0;
	int          data_errs  = 0;
	int          proto_errs = 0;
	int          overlaps   = 0;

	assign o_instr_errs = instr_errs;
	assign o_data_errs  = data_errs;
	assign o_proto_errs = proto_errs;
	assign o_overlaps   = overlaps;

	function automatic logic [15:0] model_word(input logic [15:0] addr);
		if (written.exists(addr)) begin
			return written[addr];
		end
		return addr;
	endfunction

	// inputs move 1 ns after the rising edge, so mid-cycle is settled
	always @(negedge clk) begin
		if (!rst) begin
			if (i_i_hit && i_instr !== i_i_addr) begin
				$display("mismatch instr_fetch addr %h expected %h actual %h",
					i_i_addr, i_i_addr, i_instr);
				instr_errs = instr_errs + 1;
			end
			if (!i_d_re && !i_d_we) begin
				if (i_d_hit !== 1'b1) begin
					$display("data port is idle but its hit output is not high");
					proto_errs = proto_errs + 1;
				end
			end else begin
				// first cycle of an access to the line used just before
				if (!pending && have_last && i_d_addr[15:2] == last_line && !i_d_hit) begin
					$display("repeat access to line %h did not hit in its first cycle",
						last_line);
					proto_errs = proto_errs + 1;
				end
				if (!i_i_hit && !i_d_hit) begin
					overlaps = overlaps + 1;
				end
				if (i_d_hit) begin
					if (i_d_re) begin
						expected = model_word(i_d_addr);
						if (i_d_rdata !== expected) begin
							$display("mismatch data_read addr %h expected %h actual %h",
								i_d_addr, expected, i_d_rdata);
							data_errs = data_errs + 1;
						end
					end else begin
						written[i_d_addr] = i_d_wdata;
					end
					last_line = i_d_addr[15:2];
					have_last = 1'b1;
				end
				pending = !i_d_hit;
			end
		end
	end

endmodule

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int RST_CYCLES = 8
) (
	output logic o_clk,
	output logic o_rst
);

	// 4 ns period
	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	// released just after the last reset edge, like any other input
	initial begin
		o_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge o_clk);
		#1;
		o_rst = 1'b0;
	end

endmodule

// ==== verif/cache_checker.sv ====
`timescale 1ns/1ps

module cache_checker (
	input logic                  clk,
	input logic                  rst,
	input logic                  i_i_req,
	input cache_pkg::line_addr_t i_i_addr,
	input logic                  i_d_req,
	input logic                  i_d_we,
	input cache_pkg::line_addr_t i_d_addr,
	input cache_pkg::line_u      i_d_wline,
	input logic                  i_i_done,
	input logic                  i_d_done
);

	int fail_i_done = 0;
	int fail_d_done = 0;
	int fail_gap    = 0;
	int fail_i_hold = 0;
	int fail_d_hold = 0;
	int fail_count;

	assign fail_count = fail_i_done + fail_d_done + fail_gap + fail_i_hold + fail_d_hold;

	////////////////////////////////////////
	// done pulses
	////////////////////////////////////////

	i_done_with_req: assert property (@(posedge clk) disable iff (rst) i_i_done |-> i_i_req)
	else begin
		$error("instruction done pulse without a request");
		fail_i_done = fail_i_done + 1;
	end

	d_done_with_req: assert property (@(posedge clk) disable iff (rst) i_d_done |-> i_d_req)
	else begin
		$error("data done pulse without a request");
		fail_d_done = fail_d_done + 1;
	end

	// no new grant in the cycle of done
	done_gap: assert property (@(posedge clk) disable iff (rst)
		(i_i_done || i_d_done) |=> !(i_i_done || i_d_done))
	else begin
		$error("done pulses in two consecutive cycles");
		fail_gap = fail_gap + 1;
	end

	////////////////////////////////////////
	// request hold
	////////////////////////////////////////

	i_req_hold: assert property (@(posedge clk) disable iff (rst)
		(i_i_req && !i_i_done) |=> (i_i_req && $stable(i_i_addr)))
	else begin
		$error("instruction request dropped or changed before done");
		fail_i_hold = fail_i_hold + 1;
	end

	// a writeback followed by its fill is a new request after done
	d_req_hold: assert property (@(posedge clk) disable iff (rst)
		(i_d_req && !i_d_done) |=> (i_d_req && $stable(i_d_we) && $stable(i_d_addr)
		&& $stable(i_d_wline)))
	else begin
		$error("data request dropped or changed before done");
		fail_d_hold = fail_d_hold + 1;
	end

endmodule

// ==== src/cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
	parameter int MEM_LAT = 3
) (
	input  logic             clk,
	input  logic             rst,
	input  cache_pkg::word_t i_i_addr,
	input  cache_pkg::word_t i_d_addr,
	input  logic             i_d_re,
	input  logic             i_d_we,
	input  cache_pkg::word_t i_d_wdata,
	output cache_pkg::word_t o_instr,
	output logic             o_i_hit,
	output cache_pkg::word_t o_d_rdata,
	output logic             o_d_hit
);

	import cache_pkg::*;

	// instruction refill path
	logic       ic_req;
	line_addr_t ic_addr;
	logic       ic_done;
	line_u      ic_line;

	// data writeback and refill path
	logic       dc_req;
	logic       dc_we;
	line_addr_t dc_addr;
	line_u      dc_wline;
	logic       dc_done;
	line_u      dc_rline;

	icache u_icache (
		.clk         (clk),
		.rst         (rst),
		.i_addr      (i_i_addr),
		.i_fill_done (ic_done),
		.i_fill_line (ic_line),
		.o_instr     (o_instr),
		.o_hit       (o_i_hit),
		.o_fill_req  (ic_req),
		.o_fill_addr (ic_addr)
	);

	dcache u_dcache (
		.clk         (clk),
		.rst         (rst),
		.i_addr      (i_d_addr),
		.i_re        (i_d_re),
		.i_we        (i_d_we),
		.i_wdata     (i_d_wdata),
		.i_mem_done  (dc_done),
		.i_mem_rline (dc_rline),
		.o_rdata     (o_d_rdata),
		.o_hit       (o_d_hit),
		.o_mem_req   (dc_req),
		.o_mem_we    (dc_we),
		.o_mem_addr  (dc_addr),
		.o_mem_wline (dc_wline)
	);

	main_mem_ctrl #(
		.MEM_LAT (MEM_LAT)
	) u_mem (
		.clk       (clk),
		.rst       (rst),
		.i_i_req   (ic_req),
		.i_i_addr  (ic_addr),
		.i_d_req   (dc_req),
		.i_d_we    (dc_we),
		.i_d_addr  (dc_addr),
		.i_d_wline (dc_wline),
		.o_i_done  (ic_done),
		.o_i_line  (ic_line),
		.o_d_done  (dc_done),
		.o_d_line  (dc_rline)
	);

endmodule

// ==== src/main_mem_ctrl.sv ====
`timescale 1ns/1ps

module main_mem_ctrl #(
	parameter int MEM_LAT = 3
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  i_i_req,
	input  cache_pkg::line_addr_t i_i_addr,
	input  logic                  i_d_req,
	input  logic                  i_d_we,
	input  cache_pkg::line_addr_t i_d_addr,
	input  cache_pkg::line_u      i_d_wline,
	output logic                  o_i_done,
	output cache_pkg::line_u      o_i_line,
	output logic                  o_d_done,
	output cache_pkg::line_u      o_d_line
);

	import cache_pkg::*;

	localparam int DEPTH = 2 ** $bits(line_addr_t);
	localparam int CNT_W = $clog2(MEM_LAT + 1);

	line_u mem [DEPTH];

	logic             busy_q;
	// owner of the access in flight, 1 for data
	logic             owner_q;
	logic [CNT_W-1:0] cnt_q;
	logic             done;

	// every word starts out holding its own word address
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				mem[i].words[w] = word_t'(i * LINE_WORDS + w);
			end
		end
	end

	////////////////////////////////////////
	// grant and latency
	////////////////////////////////////////

	assign done     = busy_q && (cnt_q == CNT_W'(MEM_LAT - 1));
	assign o_i_done = done && !owner_q;
	assign o_d_done = done && owner_q;

	// instruction side wins when both wait
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q  <= 1'b0;
			owner_q <= 1'b0;
			cnt_q   <= '0;
		end else if (busy_q) begin
			if (done) begin
				busy_q <= 1'b0;
				cnt_q  <= '0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end else if (i_i_req) begin
			busy_q  <= 1'b1;
			owner_q <= 1'b0;
		end else if (i_d_req) begin
			busy_q  <= 1'b1;
			owner_q <= 1'b1;
		end
	end

	////////////////////////////////////////
	// line store
	////////////////////////////////////////

	assign o_i_line = mem[i_i_addr];
	assign o_d_line = mem[i_d_addr];

	// writeback lands on the done edge
	always_ff @(posedge clk) begin
		if (o_d_done && i_d_we) begin
			mem[i_d_addr] <= i_d_wline;
		end
	end

endmodule

// ==== src/dcache.sv ====
`timescale 1ns/1ps

module dcache (
	input  logic                  clk,
	input  logic                  rst,
	input  cache_pkg::word_t      i_addr,
	input  logic                  i_re,
	input  logic                  i_we,
	input  cache_pkg::word_t      i_wdata,
	input  logic                  i_mem_done,
	input  cache_pkg::line_u      i_mem_rline,
	output cache_pkg::word_t      o_rdata,
	output logic                  o_hit,
	output logic                  o_mem_req,
	output logic                  o_mem_we,
	output cache_pkg::line_addr_t o_mem_addr,
	output cache_pkg::line_u      o_mem_wline
);

	import cache_pkg::*;

	localparam int SETS = 2 ** D_IDX_W;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WB   = 2'd1;
	localparam logic [1:0] ST_FILL = 2'd2;

	// per way state, indexed [way][set]
	logic [SETS-1:0]    valid_q [2];
	logic [SETS-1:0]    dirty_q [2];
	logic [D_TAG_W-1:0] tag_mem [2][SETS];
	line_u              line_mem [2][SETS];
	// way to replace next
	logic [SETS-1:0]    lru_q;

	logic [1:0] state_q;
	logic       vict_q;

	logic [D_IDX_W-1:0] idx;
	logic [D_TAG_W-1:0] tag;
	logic [1:0]         off;
	logic [1:0]         way_hit;
	logic               hit_way;
	logic               access;
	logic               hit_ok;
	logic               wr_hit;
	logic               fill_done;
	logic               vict_way;
	line_u              merged;

	assign idx = i_addr[D_IDX_W+1:2];
	assign tag = i_addr[15:D_IDX_W+2];
	assign off = i_addr[1:0];

	////////////////////////////////////////
	// lookup and word merge
	////////////////////////////////////////

	assign way_hit[0] = valid_q[0][idx] && (tag_mem[0][idx] == tag);
	assign way_hit[1] = valid_q[1][idx] && (tag_mem[1][idx] == tag);
	assign hit_way    = way_hit[1];
	assign access     = i_re || i_we;

	// idle port counts as a hit
	assign o_hit   = !access || (|way_hit);
	assign o_rdata = line_mem[hit_way][idx].words[off];

	assign hit_ok    = (state_q == ST_IDLE) && access && (|way_hit);
	assign wr_hit    = hit_ok && i_we;
	assign fill_done = (state_q == ST_FILL) && i_mem_done;

	always_comb begin
		merged = line_mem[hit_way][idx];
		merged.words[off] = i_wdata;
	end

	// empty way first, else lru
	assign vict_way = !valid_q[0][idx] ? 1'b0 :
	                  !valid_q[1][idx] ? 1'b1 : lru_q[idx];

	////////////////////////////////////////
	// miss FSM
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			vict_q  <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (access && !(|way_hit)) begin
						vict_q <= vict_way;
						// dirty victim goes out before the refill
						if (valid_q[vict_way][idx] && dirty_q[vict_way][idx]) begin
							state_q <= ST_WB;
						end else begin
							state_q <= ST_FILL;
						end
					end
				end
				ST_WB: begin
					if (i_mem_done) begin
						state_q <= ST_FILL;
					end
				end
				ST_FILL: begin
					if (i_mem_done) begin
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// memory side, victim address rebuilt from its own tag
	assign o_mem_req   = (state_q != ST_IDLE);
	assign o_mem_we    = (state_q == ST_WB);
	assign o_mem_addr  = (state_q == ST_WB) ? {tag_mem[vict_q][idx], idx} : i_addr[15:2];
	assign o_mem_wline = line_mem[vict_q][idx];

	////////////////////////////////////////
	// array updates
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q[0] <= '0;
			valid_q[1] <= '0;
			dirty_q[0] <= '0;
			dirty_q[1] <= '0;
			lru_q      <= '0;
		end else begin
			if (hit_ok) begin
				lru_q[idx] <= ~hit_way;
				if (i_we) begin
					dirty_q[hit_way][idx] <= 1'b1;
				end
			end
			// refilled line is clean
			if (fill_done) begin
				valid_q[vict_q][idx] <= 1'b1;
				dirty_q[vict_q][idx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_done) begin
			tag_mem[vict_q][idx]  <= tag;
			line_mem[vict_q][idx] <= i_mem_rline;
		end else if (wr_hit) begin
			line_mem[hit_way][idx] <= merged;
		end
	end

endmodule

// ==== src/icache.sv ====
`timescale 1ns/1ps

module icache (
	input  logic                  clk,
	input  logic                  rst,
	input  cache_pkg::word_t      i_addr,
	input  logic                  i_fill_done,
	input  cache_pkg::line_u      i_fill_line,
	output cache_pkg::word_t      o_instr,
	output logic                  o_hit,
	output logic                  o_fill_req,
	output cache_pkg::line_addr_t o_fill_addr
);

	import cache_pkg::*;

	localparam int LINES = 2 ** I_IDX_W;

	logic [LINES-1:0]   valid_q;
	logic [I_TAG_W-1:0] tag_mem [LINES];
	line_u              line_mem [LINES];
	logic               req_q;

	logic [I_IDX_W-1:0] idx;
	logic [I_TAG_W-1:0] tag;
	logic [1:0]         off;

	assign idx = i_addr[I_IDX_W+1:2];
	assign tag = i_addr[15:I_IDX_W+2];
	assign off = i_addr[1:0];

	////////////////////////////////////////
	// lookup
	////////////////////////////////////////

	assign o_hit   = valid_q[idx] && (tag_mem[idx] == tag);
	assign o_instr = line_mem[idx].words[off];

	////////////////////////////////////////
	// refill request
	////////////////////////////////////////

	// address is held by the fetch side until the hit
	assign o_fill_req  = req_q;
	assign o_fill_addr = i_addr[15:2];

	// raised on a miss, dropped at done
	always_ff @(posedge clk) begin
		if (rst) begin
			req_q <= 1'b0;
		end else if (i_fill_done) begin
			req_q <= 1'b0;
		end else if (!o_hit) begin
			req_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (i_fill_done) begin
			valid_q[idx] <= 1'b1;
		end
	end

	// new line lands at the done edge, fetch hits next cycle
	always_ff @(posedge clk) begin
		if (i_fill_done) begin
			tag_mem[idx]  <= tag;
			line_mem[idx] <= i_fill_line;
		end
	end

endmodule

// ==== src/cache_pkg.sv ====
package cache_pkg;

	////////////////////////////////////////
	// geometry of the 16-bit word address map
	////////////////////////////////////////

	// four words per line, offset is addr[1:0]
	localparam int LINE_WORDS = 4;

	// instruction cache, index addr[7:2] and tag addr[15:8]
	localparam int I_IDX_W = 6;
	localparam int I_TAG_W = 8;

	// data cache, index addr[6:2] and tag addr[15:7]
	localparam int D_IDX_W = 5;
	localparam int D_TAG_W = 9;

	typedef logic [15:0] word_t;

	// line address, addr[15:2]
	typedef logic [13:0] line_addr_t;

	// one cache line, seen flat by memory and as words by the caches
	typedef union packed {
		logic [LINE_WORDS*16-1:0] flat;
		word_t [LINE_WORDS-1:0]   words;
	} line_u;

endpackage
